// File: hw/uart_cfg_pkg.sv
package uart_cfg_pkg;

	// ========================================
	// Buffering
	// ========================================

	// Entries per FIFO, must be a power of two
	localparam int FIFO_DEPTH = 4;
	// Level counts 0 to FIFO_DEPTH inclusive
	localparam int W_FLEVEL = $clog2(FIFO_DEPTH + 1);

	// ========================================
	// Bit timing and frame shape
	// ========================================

	// Clock-enable pulses per bit, power of two and at least 4
	localparam int OVERSAMPLE = 8;
	localparam int W_OVER = $clog2(OVERSAMPLE);

	// 10 bits of integer divide reach below 9600 baud at 72 MHz
	localparam int W_DIV_INT = 10;
	localparam int W_DIV_FRAC = 8;

	localparam int DATA_BITS = 8;

	// State numbering shared by serializer and deserializer
	localparam int W_STATE = 4;
	localparam logic [W_STATE-1:0] ST_IDLE = 4'd0;
	localparam logic [W_STATE-1:0] ST_START = 4'd1;
	// States 2 to DATA_BITS+1 carry the data bits
	localparam logic [W_STATE-1:0] ST_STOP = 4'(DATA_BITS + 2);

endpackage

// File: hw/uart_reg_pkg.sv
package uart_reg_pkg;

	// ========================================
	// Register map
	// ========================================

	localparam logic [15:0] ADDR_CSR = 16'h0000;
	localparam logic [15:0] ADDR_DIV = 16'h0004;
	localparam logic [15:0] ADDR_FSTAT = 16'h0008;
	localparam logic [15:0] ADDR_TX = 16'h000c;
	localparam logic [15:0] ADDR_RX = 16'h0010;

	// CSR bits
	localparam int CSR_EN = 0;
	localparam int CSR_BUSY = 1;
	localparam int CSR_TXIE = 8;
	localparam int CSR_RXIE = 9;
	localparam int CSR_LOOPBACK = 10;

	// FSTAT bits, levels are 8-bit fields
	localparam int FSTAT_TXLEVEL_LSB = 0;
	localparam int FSTAT_TXFULL = 8;
	localparam int FSTAT_TXEMPTY = 9;
	localparam int FSTAT_TXOVER = 10;
	localparam int FSTAT_TXUNDER = 11;
	localparam int FSTAT_RXLEVEL_LSB = 16;
	localparam int FSTAT_RXFULL = 24;
	localparam int FSTAT_RXEMPTY = 25;
	localparam int FSTAT_RXOVER = 26;
	localparam int FSTAT_RXUNDER = 27;

	// ========================================
	// Write word views
	// ========================================

	typedef struct packed {
		logic [20:0] rsvd_hi;
		logic        loopback;
		logic        rxie;
		logic        txie;
		logic [5:0]  rsvd_lo;
		logic        busy;
		logic        en;
	} csr_view_t;

	typedef struct packed {
		logic [31-uart_cfg_pkg::W_DIV_INT-uart_cfg_pkg::W_DIV_FRAC:0] rsvd;
		logic [uart_cfg_pkg::W_DIV_INT-1:0]                          div_int;
		logic [uart_cfg_pkg::W_DIV_FRAC-1:0]                         div_frac;
	} div_view_t;

	// Same pwdata word, decoded by address
	typedef union packed {
		csr_view_t csr;
		div_view_t div;
	} apb_wword_u;

	// Divide by one, no fraction
	localparam div_view_t DIV_RESET = '{rsvd: '0, div_int: 1, div_frac: '0};

endpackage

// File: hw/clkdiv_frac.sv
`timescale 1ns/1ps

module clkdiv_frac (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                en_i,
	input  logic [uart_cfg_pkg::W_DIV_INT-1:0]  div_int_i,
	input  logic [uart_cfg_pkg::W_DIV_FRAC-1:0] div_frac_i,
	output logic                                clk_en_o
);

	// One spare bit so that div_int plus the carry cannot wrap
	localparam int W_CTR = uart_cfg_pkg::W_DIV_INT + 1;

	logic [W_CTR-1:0]                    ctr;
	logic [uart_cfg_pkg::W_DIV_FRAC-1:0] acc;
	logic [uart_cfg_pkg::W_DIV_FRAC:0]   acc_sum;
	logic                                wrap;

	assign acc_sum = {1'b0, acc} + {1'b0, div_frac_i};
	assign wrap = ctr <= W_CTR'(1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctr <= '0;
			acc <= '0;
			clk_en_o <= 1'b0;
		end else if (!en_i) begin
			ctr <= '0;
			acc <= '0;
			clk_en_o <= 1'b0;
		end else if (wrap) begin
			// Fraction overflow stretches this period by one cycle
			ctr <= {1'b0, div_int_i} + W_CTR'(acc_sum[uart_cfg_pkg::W_DIV_FRAC]);
			acc <= acc_sum[uart_cfg_pkg::W_DIV_FRAC-1:0];
			clk_en_o <= 1'b1;
		end else begin
			ctr <= ctr - 1'b1;
			clk_en_o <= 1'b0;
		end
	end

endmodule

// File: hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [WIDTH-1:0]               wdata_i,
	input  logic                           wen_i,
	output logic [WIDTH-1:0]               rdata_o,
	input  logic                           ren_i,
	output logic                           full_o,
	output logic                           empty_o,
	output logic [$clog2(DEPTH+1)-1:0]     level_o
);

	localparam int W_ADDR = $clog2(DEPTH);
	localparam int W_LEVEL = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];

	// Extra pointer bit tells full from empty
	logic [W_ADDR:0] wptr;
	logic [W_ADDR:0] rptr;
	logic            push;
	logic            pop;

	assign push = wen_i && !full_o;
	assign pop = ren_i && !empty_o;

	assign empty_o = wptr == rptr;
	assign full_o = (wptr ^ rptr) == {1'b1, {W_ADDR{1'b0}}};
	assign level_o = W_LEVEL'(wptr - rptr);

	// Head entry is visible without a read cycle
	assign rdata_o = mem[rptr[W_ADDR-1:0]];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wptr[W_ADDR-1:0]] <= wdata_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               en_i,
	input  logic                               clk_en_i,
	input  logic [uart_cfg_pkg::DATA_BITS-1:0] fifo_rdata_i,
	input  logic                               fifo_empty_i,
	output logic                               fifo_ren_o,
	output logic                               busy_o,
	output logic                               tx_o
);

	logic [uart_cfg_pkg::W_OVER-1:0]    over_ctr;
	logic [uart_cfg_pkg::W_STATE-1:0]   state;
	logic [uart_cfg_pkg::DATA_BITS-1:0] shifter;
	logic                               step;

	// A state lasts one full lap of the oversample counter
	assign step = clk_en_i && (over_ctr == '0);

	assign busy_o = (state != uart_cfg_pkg::ST_IDLE) || !fifo_empty_i;

	// New byte is taken from idle or at the end of a stop bit
	assign fifo_ren_o = en_i && step && !fifo_empty_i &&
		(state == uart_cfg_pkg::ST_IDLE || state == uart_cfg_pkg::ST_STOP);

	always_ff @(posedge clk) begin
		if (fifo_ren_o) begin
			shifter <= fifo_rdata_i;
		end else if (step && state != uart_cfg_pkg::ST_IDLE) begin
			shifter <= shifter >> 1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_o <= 1'b1;
			over_ctr <= '0;
			state <= uart_cfg_pkg::ST_IDLE;
		end else if (!en_i) begin
			tx_o <= 1'b1;
			over_ctr <= '0;
			state <= uart_cfg_pkg::ST_IDLE;
		end else begin
			if (clk_en_i) begin
				over_ctr <= over_ctr + 1'b1;
			end
			if (step) begin
				state <= state + 1'b1;
				case (state)
					uart_cfg_pkg::ST_IDLE: begin
						if (fifo_empty_i) begin
							// Counter stays at zero so a new byte starts at once
							over_ctr <= '0;
							state <= uart_cfg_pkg::ST_IDLE;
						end else begin
							tx_o <= 1'b0;
						end
					end
					uart_cfg_pkg::ST_STOP: begin
						if (fifo_empty_i) begin
							over_ctr <= '0;
							state <= uart_cfg_pkg::ST_IDLE;
						end else begin
							// Back-to-back frame
							tx_o <= 1'b0;
							state <= uart_cfg_pkg::ST_START;
						end
					end
					default: begin
						// Start and data states, the last data state raises the stop bit
						tx_o <= (state == uart_cfg_pkg::ST_STOP - 1'b1) ? 1'b1 : shifter[0];
					end
				endcase
			end
		end
	end

endmodule

// File: hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               en_i,
	input  logic                               clk_en_i,
	input  logic                               din_i,
	output logic [uart_cfg_pkg::DATA_BITS-1:0] fifo_wdata_o,
	output logic                               fifo_wen_o
);

	logic [uart_cfg_pkg::W_OVER-1:0]    over_ctr;
	logic [uart_cfg_pkg::W_STATE-1:0]   state;
	logic [uart_cfg_pkg::DATA_BITS-1:0] shifter;
	logic                               step;

	assign step = clk_en_i && (over_ctr == '0);
	assign fifo_wdata_o = shifter;

	// Data states shift in from the top, so the LSB ends up at bit 0
	always_ff @(posedge clk) begin
		if (step && state > uart_cfg_pkg::ST_START && state < uart_cfg_pkg::ST_STOP) begin
			shifter <= {din_i, shifter[uart_cfg_pkg::DATA_BITS-1:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			over_ctr <= '0;
			state <= uart_cfg_pkg::ST_IDLE;
			fifo_wen_o <= 1'b0;
		end else if (!en_i) begin
			over_ctr <= '0;
			state <= uart_cfg_pkg::ST_IDLE;
			fifo_wen_o <= 1'b0;
		end else begin
			fifo_wen_o <= 1'b0;
			if (clk_en_i) begin
				over_ctr <= over_ctr + 1'b1;
			end
			if (step) begin
				state <= state + 1'b1;
				case (state)
					uart_cfg_pkg::ST_IDLE: begin
						if (din_i) begin
							// Line still idle, keep watching every pulse
							over_ctr <= '0;
							state <= uart_cfg_pkg::ST_IDLE;
						end
					end
					uart_cfg_pkg::ST_START: begin
						// Half a bit more puts the samples at bit centres
						over_ctr <= uart_cfg_pkg::W_OVER'(uart_cfg_pkg::OVERSAMPLE / 2);
					end
					uart_cfg_pkg::ST_STOP: begin
						// Frames with a low stop bit are dropped
						fifo_wen_o <= din_i;
						// Straight to idle, half a bit of slack before the next edge
						over_ctr <= '0;
						state <= uart_cfg_pkg::ST_IDLE;
					end
					default: begin
						// Data sampled by the shifter block
					end
				endcase
			end
		end
	end

endmodule

// File: hw/uart_regs.sv
`timescale 1ns/1ps

module uart_regs (
	input  logic                                clk,
	input  logic                                rst_n,

	// APB slave
	input  logic                                psel_i,
	input  logic                                penable_i,
	input  logic                                pwrite_i,
	input  logic [15:0]                         paddr_i,
	input  logic [31:0]                         pwdata_i,
	output logic [31:0]                         prdata_o,
	output logic                                pready_o,
	output logic                                pslverr_o,

	// Control
	output logic                                en_o,
	output logic                                txie_o,
	output logic                                rxie_o,
	output logic                                loopback_o,
	output logic [uart_cfg_pkg::W_DIV_INT-1:0]  div_int_o,
	output logic [uart_cfg_pkg::W_DIV_FRAC-1:0] div_frac_o,

	// Status
	input  logic                                busy_i,
	input  logic                                txfull_i,
	input  logic                                txempty_i,
	input  logic [uart_cfg_pkg::W_FLEVEL-1:0]   txlevel_i,
	input  logic                                rxfull_i,
	input  logic                                rxempty_i,
	input  logic [uart_cfg_pkg::W_FLEVEL-1:0]   rxlevel_i,

	// TX FIFO push and pop
	output logic [uart_cfg_pkg::DATA_BITS-1:0]  tx_wdata_o,
	output logic                                tx_wen_o,
	input  logic                                tx_ren_i,

	// RX FIFO pop, plus the push strobe for overflow detection
	input  logic [uart_cfg_pkg::DATA_BITS-1:0]  rx_rdata_i,
	output logic                                rx_ren_o,
	input  logic                                rx_wen_i
);

	uart_reg_pkg::apb_wword_u wword;

	logic wr_en;
	logic rd_en;
	logic fstat_wr;
	logic txover;
	logic txunder;
	logic rxover;
	logic rxunder;

	assign wword = pwdata_i;
	assign pready_o = 1'b1;
	assign pslverr_o = 1'b0;

	assign wr_en = psel_i && penable_i && pwrite_i;
	assign rd_en = psel_i && penable_i && !pwrite_i;
	assign fstat_wr = wr_en && paddr_i == uart_reg_pkg::ADDR_FSTAT;

	// ========================================
	// FIFO strobes
	// ========================================

	assign tx_wen_o = wr_en && paddr_i == uart_reg_pkg::ADDR_TX;
	assign tx_wdata_o = pwdata_i[uart_cfg_pkg::DATA_BITS-1:0];
	assign rx_ren_o = rd_en && paddr_i == uart_reg_pkg::ADDR_RX;

	// ========================================
	// Control, divider and sticky flags
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_o <= 1'b0;
			txie_o <= 1'b0;
			rxie_o <= 1'b0;
			loopback_o <= 1'b0;
			div_int_o <= uart_reg_pkg::DIV_RESET.div_int;
			div_frac_o <= uart_reg_pkg::DIV_RESET.div_frac;
		end else if (wr_en && paddr_i == uart_reg_pkg::ADDR_CSR) begin
			en_o <= wword.csr.en;
			txie_o <= wword.csr.txie;
			rxie_o <= wword.csr.rxie;
			loopback_o <= wword.csr.loopback;
		end else if (wr_en && paddr_i == uart_reg_pkg::ADDR_DIV) begin
			div_int_o <= wword.div.div_int;
			div_frac_o <= wword.div.div_frac;
		end
	end

	// A new error in the clearing cycle wins over the clear
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			txover <= 1'b0;
			txunder <= 1'b0;
			rxover <= 1'b0;
			rxunder <= 1'b0;
		end else begin
			txover <= (txover && !(fstat_wr && pwdata_i[uart_reg_pkg::FSTAT_TXOVER])) ||
				(tx_wen_o && txfull_i);
			txunder <= (txunder && !(fstat_wr && pwdata_i[uart_reg_pkg::FSTAT_TXUNDER])) ||
				(tx_ren_i && txempty_i);
			rxover <= (rxover && !(fstat_wr && pwdata_i[uart_reg_pkg::FSTAT_RXOVER])) ||
				(rx_wen_i && rxfull_i);
			rxunder <= (rxunder && !(fstat_wr && pwdata_i[uart_reg_pkg::FSTAT_RXUNDER])) ||
				(rx_ren_o && rxempty_i);
		end
	end

	// ========================================
	// Read mux
	// ========================================

	always_comb begin
		prdata_o = '0;
		case (paddr_i)
			uart_reg_pkg::ADDR_CSR: begin
				prdata_o[uart_reg_pkg::CSR_EN] = en_o;
				prdata_o[uart_reg_pkg::CSR_BUSY] = busy_i;
				prdata_o[uart_reg_pkg::CSR_TXIE] = txie_o;
				prdata_o[uart_reg_pkg::CSR_RXIE] = rxie_o;
				prdata_o[uart_reg_pkg::CSR_LOOPBACK] = loopback_o;
			end
			uart_reg_pkg::ADDR_DIV: begin
				prdata_o[uart_cfg_pkg::W_DIV_FRAC-1:0] = div_frac_o;
				prdata_o[uart_cfg_pkg::W_DIV_FRAC +: uart_cfg_pkg::W_DIV_INT] = div_int_o;
			end
			uart_reg_pkg::ADDR_FSTAT: begin
				prdata_o[uart_reg_pkg::FSTAT_TXLEVEL_LSB +: uart_cfg_pkg::W_FLEVEL] = txlevel_i;
				prdata_o[uart_reg_pkg::FSTAT_TXFULL] = txfull_i;
				prdata_o[uart_reg_pkg::FSTAT_TXEMPTY] = txempty_i;
				prdata_o[uart_reg_pkg::FSTAT_TXOVER] = txover;
				prdata_o[uart_reg_pkg::FSTAT_TXUNDER] = txunder;
				prdata_o[uart_reg_pkg::FSTAT_RXLEVEL_LSB +: uart_cfg_pkg::W_FLEVEL] = rxlevel_i;
				prdata_o[uart_reg_pkg::FSTAT_RXFULL] = rxfull_i;
				prdata_o[uart_reg_pkg::FSTAT_RXEMPTY] = rxempty_i;
				prdata_o[uart_reg_pkg::FSTAT_RXOVER] = rxover;
				prdata_o[uart_reg_pkg::FSTAT_RXUNDER] = rxunder;
			end
			uart_reg_pkg::ADDR_RX: begin
				prdata_o[uart_cfg_pkg::DATA_BITS-1:0] = rx_rdata_i;
			end
			default: begin
				// TX data and unmapped addresses read as zero
			end
		endcase
	end

endmodule

// File: hw/uart_mini.sv
`timescale 1ns/1ps

module uart_mini (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [15:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o,
	input  logic        rx_i,
	output logic        tx_o,
	output logic        irq_o,
	output logic        dreq_o
);

	logic [uart_cfg_pkg::DATA_BITS-1:0]  tx_wdata;
	logic                                tx_wen;
	logic [uart_cfg_pkg::DATA_BITS-1:0]  tx_rdata;
	logic                                tx_ren;
	logic                                tx_full;
	logic                                tx_empty;
	logic [uart_cfg_pkg::W_FLEVEL-1:0]   tx_level;

	logic [uart_cfg_pkg::DATA_BITS-1:0]  rx_wdata;
	logic                                rx_wen;
	logic [uart_cfg_pkg::DATA_BITS-1:0]  rx_rdata;
	logic                                rx_ren;
	logic                                rx_full;
	logic                                rx_empty;
	logic [uart_cfg_pkg::W_FLEVEL-1:0]   rx_level;

	logic                                en;
	logic                                txie;
	logic                                rxie;
	logic                                loopback;
	logic                                busy;
	logic                                clk_en;
	logic                                din;
	logic [uart_cfg_pkg::W_DIV_INT-1:0]  div_int;
	logic [uart_cfg_pkg::W_DIV_FRAC-1:0] div_frac;

	// Loopback feeds our own serial output back to the receiver
	assign din = loopback ? tx_o : rx_i;

	assign irq_o = (txie && !tx_full) || (rxie && !rx_empty);
	assign dreq_o = irq_o;

	clkdiv_frac u_clkdiv (
		.clk(clk), .rst_n(rst_n), .en_i(en),
		.div_int_i(div_int), .div_frac_i(div_frac), .clk_en_o(clk_en)
	);

	sync_fifo #(.DEPTH(uart_cfg_pkg::FIFO_DEPTH), .WIDTH(uart_cfg_pkg::DATA_BITS)) u_txfifo (
		.clk(clk), .rst_n(rst_n), .wdata_i(tx_wdata), .wen_i(tx_wen),
		.rdata_o(tx_rdata), .ren_i(tx_ren),
		.full_o(tx_full), .empty_o(tx_empty), .level_o(tx_level)
	);

	sync_fifo #(.DEPTH(uart_cfg_pkg::FIFO_DEPTH), .WIDTH(uart_cfg_pkg::DATA_BITS)) u_rxfifo (
		.clk(clk), .rst_n(rst_n), .wdata_i(rx_wdata), .wen_i(rx_wen),
		.rdata_o(rx_rdata), .ren_i(rx_ren),
		.full_o(rx_full), .empty_o(rx_empty), .level_o(rx_level)
	);

	uart_tx u_tx (
		.clk(clk), .rst_n(rst_n), .en_i(en), .clk_en_i(clk_en),
		.fifo_rdata_i(tx_rdata), .fifo_empty_i(tx_empty), .fifo_ren_o(tx_ren),
		.busy_o(busy), .tx_o(tx_o)
	);

	uart_rx u_rx (
		.clk(clk), .rst_n(rst_n), .en_i(en), .clk_en_i(clk_en), .din_i(din),
		.fifo_wdata_o(rx_wdata), .fifo_wen_o(rx_wen)
	);

	uart_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o),
		.en_o(en), .txie_o(txie), .rxie_o(rxie), .loopback_o(loopback),
		.div_int_o(div_int), .div_frac_o(div_frac),
		.busy_i(busy), .txfull_i(tx_full), .txempty_i(tx_empty), .txlevel_i(tx_level),
		.rxfull_i(rx_full), .rxempty_i(rx_empty), .rxlevel_i(rx_level),
		.tx_wdata_o(tx_wdata), .tx_wen_o(tx_wen), .tx_ren_i(tx_ren),
		.rx_rdata_i(rx_rdata), .rx_ren_o(rx_ren), .rx_wen_i(rx_wen)
	);

endmodule

// File: tests/tb_uart_mini.sv
`timescale 1ns/1ps

module tb_uart_mini;

	// Divider 2 with no fraction gives 16 clocks per bit
	localparam int DIV_INT = 2;
	localparam int BIT_CLKS = DIV_INT * uart_cfg_pkg::OVERSAMPLE;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;
	// TX check, looped burst plus overflow byte, irq byte, bad frame, quiet frame, good frame
	localparam int NUM_FRAMES = uart_cfg_pkg::FIFO_DEPTH + 6;
	localparam int TIMEOUT_CLKS = NUM_FRAMES * FRAME_CLKS + 2000;

	// Low stop bit released just after the receiver samples it,
	// so the idle line that follows is not read as a new start bit
	localparam int STOP_LOW_CLKS = 12;

	localparam logic [31:0] CSR_EN = 32'h0000_0001;
	localparam logic [31:0] CSR_BUSY = 32'h0000_0002;
	localparam logic [31:0] CSR_TXIE = 32'h0000_0100;
	localparam logic [31:0] CSR_RXIE = 32'h0000_0200;
	localparam logic [31:0] CSR_LOOPBACK = 32'h0000_0400;

	// FIFO flag nibble, full in the low bit up to under in the top bit
	localparam logic [3:0] FL_FULL = 4'b0001;
	localparam logic [3:0] FL_EMPTY = 4'b0010;
	localparam logic [3:0] FL_OVER = 4'b0100;
	localparam logic [3:0] FL_UNDER = 4'b1000;

	logic        clk;
	logic        rst_n;
	logic        psel_i;
	logic        penable_i;
	logic        pwrite_i;
	logic [15:0] paddr_i;
	logic [31:0] pwdata_i;
	logic [31:0] prdata_o;
	logic        pready_o;
	logic        pslverr_o;
	logic        rx_i;
	logic        tx_o;
	logic        irq_o;
	logic        dreq_o;

	logic [31:0] rng_state;
	logic [7:0]  sent[$];

	uart_mini u_dut (
		.clk(clk), .rst_n(rst_n),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o),
		.rx_i(rx_i), .tx_o(tx_o), .irq_o(irq_o), .dreq_o(dreq_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// Reporting and reference helpers
	// ========================================

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			stop_on_error($sformatf("Fail %s: expected 0x%h, got 0x%h", name, exp, act));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] rand_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	// Expected FSTAT word, levels in 8-bit fields and flags above each level
	function automatic logic [31:0] fstat_word(input int txlevel, input logic [3:0] txflags,
		input int rxlevel, input logic [3:0] rxflags);
		logic [31:0] w;
		w = '0;
		w[7:0] = 8'(txlevel);
		w[11:8] = txflags;
		w[23:16] = 8'(rxlevel);
		w[27:24] = rxflags;
		return w;
	endfunction

	// ========================================
	// Bus and line drivers
	// ========================================

	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
		@(posedge clk);
		psel_i <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i <= 1'b1;
		paddr_i <= addr;
		pwdata_i <= data;
		@(posedge clk);
		penable_i <= 1'b1;
		@(posedge clk);
		psel_i <= 1'b0;
		penable_i <= 1'b0;
		pwrite_i <= 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
		@(posedge clk);
		psel_i <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i <= 1'b0;
		paddr_i <= addr;
		@(posedge clk);
		penable_i <= 1'b1;
		// Read data follows paddr, settled by mid-cycle
		@(negedge clk);
		data = prdata_o;
		@(posedge clk);
		psel_i <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic read_expect(input logic [15:0] addr, input string name,
		input logic [31:0] exp);
		logic [31:0] rd;
		apb_read(addr, rd);
		check_value(name, exp, rd);
	endtask

	task automatic wait_rx_level(input int level);
		logic [31:0] rd;
		do begin
			apb_read(uart_reg_pkg::ADDR_FSTAT, rd);
		end while (rd[uart_reg_pkg::FSTAT_RXLEVEL_LSB +: 8] != 8'(level));
	endtask

	task automatic wait_fstat_bit(input int bit_pos);
		logic [31:0] rd;
		do begin
			apb_read(uart_reg_pkg::ADDR_FSTAT, rd);
		end while (!rd[bit_pos]);
	endtask

	task automatic wait_tx_idle();
		logic [31:0] rd;
		do begin
			apb_read(uart_reg_pkg::ADDR_CSR, rd);
		end while (rd[uart_reg_pkg::CSR_BUSY]);
	endtask

	// Sample each bit at its centre, counted from the start bit edge
	task automatic sample_tx_frame(input logic [7:0] data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0};
		@(negedge tx_o);
		repeat (BIT_CLKS / 2) @(negedge clk);
		for (int i = 0; i < 10; i++) begin
			check_value($sformatf("tx_o bit %0d", i), 32'(bits[i]), 32'(tx_o));
			if (i < 9) begin
				repeat (BIT_CLKS) @(negedge clk);
			end
		end
	endtask

	task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
		logic [8:0] bits;
		bits = {data, 1'b0};
		for (int i = 0; i < 9; i++) begin
			@(posedge clk);
			rx_i <= bits[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		rx_i <= stop_bit;
		if (!stop_bit) begin
			repeat (STOP_LOW_CLKS) @(posedge clk);
			rx_i <= 1'b1;
		end
		repeat (2 * BIT_CLKS) @(posedge clk);
	endtask

	// ========================================
	// Checks and watchdog
	// ========================================

	assert property (@(posedge clk) disable iff (!rst_n) dreq_o == irq_o)
		else stop_on_error($sformatf("Fail dreq_o: expected 0x%h, got 0x%h", irq_o, dreq_o));

	assert property (@(posedge clk) disable iff (!rst_n) pready_o && !pslverr_o)
		else stop_on_error("APB slave stalled or flagged an error");

	initial begin
		repeat (TIMEOUT_CLKS) @(posedge clk);
		stop_on_error($sformatf("Watchdog expired after %0d clocks", TIMEOUT_CLKS));
	end

	initial begin
		logic [31:0] rd;
		logic [7:0]  b;
		rng_state = 32'd11074;
		rst_n = 1'b0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		rx_i = 1'b1;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// Reset values
		@(negedge clk);
		check_value("tx_o", 32'h1, 32'(tx_o));
		check_value("irq_o", 32'h0, 32'(irq_o));
		check_value("dreq_o", 32'h0, 32'(dreq_o));
		check_value("pready_o", 32'h1, 32'(pready_o));
		read_expect(uart_reg_pkg::ADDR_CSR, "CSR", 32'h0);
		read_expect(uart_reg_pkg::ADDR_DIV, "DIV", 32'h0000_0100);
		read_expect(uart_reg_pkg::ADDR_FSTAT, "FSTAT", fstat_word(0, FL_EMPTY, 0, FL_EMPTY));

		// Single frame on tx_o
		apb_write(uart_reg_pkg::ADDR_DIV, {14'h0, 10'(DIV_INT), 8'h00});
		apb_write(uart_reg_pkg::ADDR_CSR, CSR_EN);
		b = rand_byte();
		apb_write(uart_reg_pkg::ADDR_TX, {24'h0, b});
		sample_tx_frame(b);
		wait_tx_idle();
		read_expect(uart_reg_pkg::ADDR_CSR, "CSR", CSR_EN);

		// Loopback burst fills the RX FIFO, one extra frame overflows it
		apb_write(uart_reg_pkg::ADDR_CSR, CSR_EN | CSR_LOOPBACK);
		for (int i = 0; i < uart_cfg_pkg::FIFO_DEPTH + 1; i++) begin
			b = rand_byte();
			if (i < uart_cfg_pkg::FIFO_DEPTH) begin
				sent.push_back(b);
			end
			apb_write(uart_reg_pkg::ADDR_TX, {24'h0, b});
		end
		wait_fstat_bit(uart_reg_pkg::FSTAT_RXOVER);
		read_expect(uart_reg_pkg::ADDR_FSTAT, "FSTAT",
			fstat_word(0, FL_EMPTY, uart_cfg_pkg::FIFO_DEPTH, FL_FULL | FL_OVER));
		while (sent.size() > 0) begin
			b = sent.pop_front();
			read_expect(uart_reg_pkg::ADDR_RX, "RX data", {24'h0, b});
		end
		apb_write(uart_reg_pkg::ADDR_FSTAT, fstat_word(0, 4'b0000, 0, FL_OVER));
		read_expect(uart_reg_pkg::ADDR_FSTAT, "FSTAT", fstat_word(0, FL_EMPTY, 0, FL_EMPTY));

		// RX interrupt tracks a non-empty RX FIFO
		apb_write(uart_reg_pkg::ADDR_CSR, CSR_EN | CSR_LOOPBACK | CSR_RXIE);
		@(negedge clk);
		check_value("irq_o", 32'h0, 32'(irq_o));
		b = rand_byte();
		apb_write(uart_reg_pkg::ADDR_TX, {24'h0, b});
		wait_rx_level(1);
		@(negedge clk);
		check_value("irq_o", 32'h1, 32'(irq_o));
		read_expect(uart_reg_pkg::ADDR_RX, "RX data", {24'h0, b});
		@(negedge clk);
		check_value("irq_o", 32'h0, 32'(irq_o));

		// TX interrupt tracks a TX FIFO with room, UART disabled so nothing drains
		apb_write(uart_reg_pkg::ADDR_CSR, CSR_TXIE);
		@(negedge clk);
		check_value("irq_o", 32'h1, 32'(irq_o));
		for (int i = 0; i < uart_cfg_pkg::FIFO_DEPTH; i++) begin
			apb_write(uart_reg_pkg::ADDR_TX, {24'h0, rand_byte()});
			@(negedge clk);
			check_value("irq_o", 32'(i + 1 < uart_cfg_pkg::FIFO_DEPTH), 32'(irq_o));
		end

		// Sticky flags, one push too many and a pop from empty
		apb_write(uart_reg_pkg::ADDR_TX, {24'h0, rand_byte()});
		read_expect(uart_reg_pkg::ADDR_FSTAT, "FSTAT",
			fstat_word(uart_cfg_pkg::FIFO_DEPTH, FL_FULL | FL_OVER, 0, FL_EMPTY));
		check_value("tx_o", 32'h1, 32'(tx_o));
		// Queued bytes keep the transmitter busy
		read_expect(uart_reg_pkg::ADDR_CSR, "CSR", CSR_TXIE | CSR_BUSY);
		apb_read(uart_reg_pkg::ADDR_RX, rd);
		read_expect(uart_reg_pkg::ADDR_FSTAT, "FSTAT",
			fstat_word(uart_cfg_pkg::FIFO_DEPTH, FL_FULL | FL_OVER, 0, FL_EMPTY | FL_UNDER));
		apb_write(uart_reg_pkg::ADDR_FSTAT, fstat_word(0, FL_OVER, 0, FL_UNDER));
		read_expect(uart_reg_pkg::ADDR_FSTAT, "FSTAT",
			fstat_word(uart_cfg_pkg::FIFO_DEPTH, FL_FULL, 0, FL_EMPTY));

		// Framing, a low stop bit drops the byte and a clean frame follows
		apb_write(uart_reg_pkg::ADDR_CSR, CSR_EN);
		drive_frame(rand_byte(), 1'b0);
		repeat (FRAME_CLKS) @(posedge clk);
		apb_read(uart_reg_pkg::ADDR_FSTAT, rd);
		check_value("rxlevel", 32'h0, 32'(rd[uart_reg_pkg::FSTAT_RXLEVEL_LSB +: 8]));
		b = rand_byte();
		drive_frame(b, 1'b1);
		wait_rx_level(1);
		read_expect(uart_reg_pkg::ADDR_RX, "RX data", {24'h0, b});

		$display("all tests passed");
		$finish;
	end

endmodule

// File: build.f
hw/uart_cfg_pkg.sv
hw/uart_reg_pkg.sv
hw/clkdiv_frac.sv
hw/sync_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_mini.sv
tests/tb_uart_mini.sv

// File: Makefile
# Verilator build and run of the UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_mini
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
